// ==== jbus_pkg.sv ====
// JBus field definitions
`default_nettype none

package jbus_pkg;

  // Bus widths
  localparam int AD_W     = 128;
  localparam int ADTYPE_W = 8;
  localparam int ADP_W    = 4;
  localparam int LANE_W   = 32;

  // JID is target agent in [5:2], transaction id in [1:0]
  localparam int JID_W = 6;

  // Two-bit J_ADTYPE prefixes
  localparam logic [1:0] ADTYPE_RDER = 2'd0;
  localparam logic [1:0] ADTYPE_RD64 = 2'd1;
  localparam logic [1:0] ADTYPE_RD16 = 2'd2;
  localparam logic [1:0] ADTYPE_NC   = 2'd3;

  // Transaction codes in an address half
  localparam int TRANS_W = 5;
  localparam logic [TRANS_W-1:0] TRANS_NCRD    = 5'h0c;
  localparam logic [TRANS_W-1:0] TRANS_NCWR    = 5'h0e;
  localparam logic [TRANS_W-1:0] TRANS_INTACK  = 5'h14;
  localparam logic [TRANS_W-1:0] TRANS_INTNACK = 5'h15;

  // Address half layout: byte enables, code, address
  localparam int PIO_ADDR_W = 43;
  localparam int BE_W       = 16;
  localparam int AID_W      = 5;

  // Install state sent in RD64 cycle 1
  localparam logic [2:0] INSTALL_INVALID = 3'b000;
  localparam logic [2:0] INSTALL_SHARED  = 3'b001;

  // Error codes in the low bits of an RDER data cycle
  localparam logic [2:0] RDER_UNMAPPED  = 3'b010;
  localparam logic [2:0] RDER_BUS_ERROR = 3'b011;

  // Debug queue returns always go to this agent
  localparam logic [3:0] DBG_TARGET_AID = 4'd4;

  // Undriven bus reads as all ones
  localparam logic [ADTYPE_W-1:0] IDLE_ADTYPE = '1;

endpackage

`default_nettype wire

// ==== pktout_sel_pkg.sv ====
// Packet output select encodings
`default_nettype none

package pktout_sel_pkg;

  // Queue select
  localparam int QSEL_W = 3;
  localparam logic [QSEL_W-1:0] LRQ_SCT0RDQ = 3'd0;
  localparam logic [QSEL_W-1:0] LRQ_SCT1RDQ = 3'd1;
  localparam logic [QSEL_W-1:0] LRQ_SCT2RDQ = 3'd2;
  localparam logic [QSEL_W-1:0] LRQ_SCT3RDQ = 3'd3;
  localparam logic [QSEL_W-1:0] LRQ_PIORQQ  = 3'd4;
  localparam logic [QSEL_W-1:0] LRQ_PIOACKQ = 3'd5;
  localparam logic [QSEL_W-1:0] LRQ_DBGQ    = 3'd6;

  localparam int NUM_SCT = 4;

  // Bus-cycle select, idle is legal with any queue
  localparam int CSEL_W = 4;
  localparam logic [CSEL_W-1:0] SEL_IDLE    = 4'd0;
  localparam logic [CSEL_W-1:0] SEL_RD16    = 4'd1;
  localparam logic [CSEL_W-1:0] SEL_RD64_0  = 4'd2;
  localparam logic [CSEL_W-1:0] SEL_RD64_1  = 4'd3;
  localparam logic [CSEL_W-1:0] SEL_RD64_2  = 4'd4;
  localparam logic [CSEL_W-1:0] SEL_RD64_3  = 4'd5;
  localparam logic [CSEL_W-1:0] SEL_RDER    = 4'd6;
  localparam logic [CSEL_W-1:0] SEL_NCRD    = 4'd7;
  localparam logic [CSEL_W-1:0] SEL_NCWR_0  = 4'd8;
  localparam logic [CSEL_W-1:0] SEL_NCWR_1  = 4'd9;
  localparam logic [CSEL_W-1:0] SEL_INTACK  = 4'd10;
  localparam logic [CSEL_W-1:0] SEL_INTNACK = 4'd11;

endpackage

`default_nettype wire

// ==== sct_rdq_format.sv ====
// L2 read-return cycle formatter
`timescale 1ns/10ps
`default_nettype none

module sct_rdq_format (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              install_state,
  input  logic                              unmapped_error,
  input  logic                              ue_err,
  input  logic [jbus_pkg::JID_W-1:0]        jid,
  input  logic [jbus_pkg::AD_W-1:0]         data,
  input  logic [pktout_sel_pkg::CSEL_W-1:0] sel_j_adbus,
  output logic [jbus_pkg::ADTYPE_W-1:0]     adtype,
  output logic [jbus_pkg::AD_W-1:0]         ad
);
  import jbus_pkg::*;
  import pktout_sel_pkg::*;

  logic       ue_err_q;
  logic [2:0] rd64_state;
  logic [2:0] rder_code;

  // UE of the previous cycle, reported again in RD64 cycle 1
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ue_err_q <= 1'b0;
    end else begin
      ue_err_q <= ue_err;
    end
  end

  assign rd64_state = install_state ? INSTALL_SHARED : INSTALL_INVALID;
  assign rder_code  = unmapped_error ? RDER_UNMAPPED : RDER_BUS_ERROR;

  always_comb begin
    adtype = '0;
    ad     = '0;
    case (sel_j_adbus)
      SEL_RD16: begin
        adtype = {ADTYPE_RD16, jid};
        ad     = data;
      end
      SEL_RD64_0: begin
        adtype = {ADTYPE_RD64, jid};
        ad     = data;
      end
      // Bit 6 delayed UE, bit 4 current UE, bits 2:0 install state
      SEL_RD64_1: begin
        adtype = {1'b0, ue_err_q, 1'b0, ue_err, 1'b0, rd64_state};
        ad     = data;
      end
      SEL_RD64_2, SEL_RD64_3: begin
        adtype = {3'b000, ue_err, 4'b0000};
        ad     = data;
      end
      SEL_RDER: begin
        adtype = {ADTYPE_RDER, jid};
        ad     = {data[AD_W-1:3], rder_code};
      end
      default: begin
        adtype = '0;
        ad     = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== ncio_format.sv ====
// PIO request and interrupt ack formatter
`timescale 1ns/10ps
`default_nettype none

module ncio_format (
  input  logic [pktout_sel_pkg::CSEL_W-1:0] sel_j_adbus,
  input  logic                              pio_ue,
  input  logic [jbus_pkg::BE_W-1:0]         pio_be,
  input  logic [jbus_pkg::AD_W/2-1:0]       pio_ad,
  input  logic [jbus_pkg::AID_W-1:0]        mondo_agnt_id,
  input  logic [jbus_pkg::AID_W-1:0]        mondo_cpu_id,
  input  logic [jbus_pkg::JID_W-1:0]        unused_jid,
  output logic [jbus_pkg::ADTYPE_W-1:0]     adtype,
  output logic [jbus_pkg::AD_W-1:0]         ad
);
  import jbus_pkg::*;
  import pktout_sel_pkg::*;

  logic [AD_W/2-1:0] ncrd_half;
  logic [AD_W/2-1:0] ncwr_half;
  logic [AD_W/2-1:0] intack_half;
  logic [AD_W/2-1:0] intnack_half;

  // Address halves: byte enables, transaction, address
  assign ncrd_half = {pio_be, TRANS_NCRD, pio_ad[PIO_ADDR_W-1:0]};
  assign ncwr_half = {pio_be, TRANS_NCWR, pio_ad[PIO_ADDR_W-1:0]};

  // Mondo ack: target then source agent, low 31 bits unused
  assign intack_half  = {{BE_W{1'b0}}, TRANS_INTACK, 2'b00,
                         mondo_agnt_id, mondo_cpu_id, 31'd0};
  assign intnack_half = {{BE_W{1'b0}}, TRANS_INTNACK, 2'b00,
                         mondo_agnt_id, mondo_cpu_id, 31'd0};

  // Address cycles carry the same half twice
  always_comb begin
    adtype = '0;
    ad     = '0;
    case (sel_j_adbus)
      SEL_NCRD: begin
        adtype = {ADTYPE_NC, unused_jid};
        ad     = {ncrd_half, ncrd_half};
      end
      SEL_NCWR_0: begin
        adtype = {ADTYPE_NC, {JID_W{1'b0}}};
        ad     = {ncwr_half, ncwr_half};
      end
      // Write data cycle
      SEL_NCWR_1: begin
        adtype = {3'b000, pio_ue, 4'b0000};
        ad     = {pio_ad, pio_ad};
      end
      SEL_INTACK: begin
        adtype = {ADTYPE_NC, {JID_W{1'b0}}};
        ad     = {intack_half, intack_half};
      end
      SEL_INTNACK: begin
        adtype = {ADTYPE_NC, {JID_W{1'b0}}};
        ad     = {intnack_half, intnack_half};
      end
      default: begin
        adtype = '0;
        ad     = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== pktout_select.sv ====
// JBus packet source selector
`timescale 1ns/10ps
`default_nettype none

module pktout_select (
  input  logic [pktout_sel_pkg::QSEL_W-1:0] sel_queue,
  input  logic [pktout_sel_pkg::CSEL_W-1:0] sel_j_adbus,
  input  logic [jbus_pkg::ADTYPE_W-1:0]     sct_adtype [pktout_sel_pkg::NUM_SCT],
  input  logic [jbus_pkg::AD_W-1:0]         sct_ad [pktout_sel_pkg::NUM_SCT],
  input  logic [jbus_pkg::ADTYPE_W-1:0]     ncio_adtype,
  input  logic [jbus_pkg::AD_W-1:0]         ncio_ad,
  input  logic [jbus_pkg::AD_W-1:0]         dbg_data,
  output logic [jbus_pkg::ADTYPE_W-1:0]     j_adtype,
  output logic [jbus_pkg::AD_W-1:0]         j_ad
);
  import jbus_pkg::*;
  import pktout_sel_pkg::*;

  logic piorq_cycle;
  logic pioack_cycle;

  // PIO queues only own their own cycle types
  assign piorq_cycle  = (sel_j_adbus == SEL_NCRD) || (sel_j_adbus == SEL_NCWR_0) ||
                        (sel_j_adbus == SEL_NCWR_1);
  assign pioack_cycle = (sel_j_adbus == SEL_INTACK) || (sel_j_adbus == SEL_INTNACK);

  always_comb begin
    j_adtype = '0;
    j_ad     = '0;
    if (sel_j_adbus == SEL_IDLE) begin
      j_adtype = IDLE_ADTYPE;
      j_ad     = '1;
    end else begin
      case (sel_queue)
        // SCT formatters already zero the cycles they do not own
        LRQ_SCT0RDQ: begin
          j_adtype = sct_adtype[0];
          j_ad     = sct_ad[0];
        end
        LRQ_SCT1RDQ: begin
          j_adtype = sct_adtype[1];
          j_ad     = sct_ad[1];
        end
        LRQ_SCT2RDQ: begin
          j_adtype = sct_adtype[2];
          j_ad     = sct_ad[2];
        end
        LRQ_SCT3RDQ: begin
          j_adtype = sct_adtype[3];
          j_ad     = sct_ad[3];
        end
        LRQ_PIORQQ: begin
          if (piorq_cycle) begin
            j_adtype = ncio_adtype;
            j_ad     = ncio_ad;
          end
        end
        LRQ_PIOACKQ: begin
          if (pioack_cycle) begin
            j_adtype = ncio_adtype;
            j_ad     = ncio_ad;
          end
        end
        // Debug data goes out as an RD16 return, transaction 0
        LRQ_DBGQ: begin
          if (sel_j_adbus == SEL_RD16) begin
            j_adtype = {ADTYPE_RD16, DBG_TARGET_AID, 2'b00};
            j_ad     = dbg_data;
          end
        end
        default: begin
          j_adtype = '0;
          j_ad     = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== jad_protect.sv ====
// J_AD error injection and parity
`timescale 1ns/10ps
`default_nettype none

module jad_protect (
  input  logic [jbus_pkg::ADTYPE_W-1:0] j_adtype,
  input  logic [jbus_pkg::AD_W-1:0]     j_ad,
  input  logic [jbus_pkg::ADP_W-1:0]    inj_err_j_ad,
  output logic [jbus_pkg::AD_W-1:0]     jbi_io_j_ad,
  output logic [jbus_pkg::ADP_W-1:0]    jbi_io_j_adp
);
  import jbus_pkg::*;

  for (genvar k = 0; k < ADP_W; k++) begin : g_lane
    // Flip only bit 0 of the lane
    assign jbi_io_j_ad[k*LANE_W +: LANE_W] =
      j_ad[k*LANE_W +: LANE_W] ^ {{(LANE_W-1){1'b0}}, inj_err_j_ad[k]};

    // Odd parity over clean data, top lane covers ADTYPE too
    if (k == ADP_W-1) begin : g_top
      assign jbi_io_j_adp[k] = ~((^j_ad[k*LANE_W +: LANE_W]) ^ (^j_adtype));
    end else begin : g_low
      assign jbi_io_j_adp[k] = ~(^j_ad[k*LANE_W +: LANE_W]);
    end
  end

endmodule

`default_nettype wire

// ==== jbi_pktout_mux.sv ====
// JBus packet output formatter top
`timescale 1ns/10ps
`default_nettype none

module jbi_pktout_mux (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic [pktout_sel_pkg::QSEL_W-1:0] sel_queue,
  input  logic [pktout_sel_pkg::CSEL_W-1:0] sel_j_adbus,
  // L2 read-return queues
  input  logic                              sct0rdq_install_state,
  input  logic                              sct0rdq_unmapped_error,
  input  logic [jbus_pkg::JID_W-1:0]        sct0rdq_jid,
  input  logic [jbus_pkg::AD_W-1:0]         sct0rdq_data,
  input  logic                              sct0rdq_ue_err,
  input  logic                              sct1rdq_install_state,
  input  logic                              sct1rdq_unmapped_error,
  input  logic [jbus_pkg::JID_W-1:0]        sct1rdq_jid,
  input  logic [jbus_pkg::AD_W-1:0]         sct1rdq_data,
  input  logic                              sct1rdq_ue_err,
  input  logic                              sct2rdq_install_state,
  input  logic                              sct2rdq_unmapped_error,
  input  logic [jbus_pkg::JID_W-1:0]        sct2rdq_jid,
  input  logic [jbus_pkg::AD_W-1:0]         sct2rdq_data,
  input  logic                              sct2rdq_ue_err,
  input  logic                              sct3rdq_install_state,
  input  logic                              sct3rdq_unmapped_error,
  input  logic [jbus_pkg::JID_W-1:0]        sct3rdq_jid,
  input  logic [jbus_pkg::AD_W-1:0]         sct3rdq_data,
  input  logic                              sct3rdq_ue_err,
  // PIO request and ack queues
  input  logic                              ncio_pio_ue,
  input  logic [jbus_pkg::BE_W-1:0]         ncio_pio_be,
  input  logic [jbus_pkg::AD_W/2-1:0]       ncio_pio_ad,
  input  logic [jbus_pkg::AID_W-1:0]        ncio_mondo_agnt_id,
  input  logic [jbus_pkg::AID_W-1:0]        ncio_mondo_cpu_id,
  input  logic [jbus_pkg::JID_W-1:0]        unused_jid,
  input  logic [jbus_pkg::AD_W-1:0]         dbg_data,
  input  logic [jbus_pkg::ADP_W-1:0]        inj_err_j_ad,
  output logic [jbus_pkg::ADTYPE_W-1:0]     jbi_io_j_adtype,
  output logic [jbus_pkg::AD_W-1:0]         jbi_io_j_ad,
  output logic [jbus_pkg::ADP_W-1:0]        jbi_io_j_adp
);
  import jbus_pkg::*;
  import pktout_sel_pkg::*;

  logic [ADTYPE_W-1:0] sct_adtype [NUM_SCT];
  logic [AD_W-1:0]     sct_ad [NUM_SCT];
  logic [ADTYPE_W-1:0] ncio_adtype;
  logic [AD_W-1:0]     ncio_ad;
  logic [AD_W-1:0]     j_ad;

  sct_rdq_format sct0_fmt_i (
    .clk, .arst_n, .sel_j_adbus,
    .install_state (sct0rdq_install_state),
    .unmapped_error(sct0rdq_unmapped_error),
    .ue_err        (sct0rdq_ue_err),
    .jid           (sct0rdq_jid),
    .data          (sct0rdq_data),
    .adtype        (sct_adtype[0]),
    .ad            (sct_ad[0])
  );

  sct_rdq_format sct1_fmt_i (
    .clk, .arst_n, .sel_j_adbus,
    .install_state (sct1rdq_install_state),
    .unmapped_error(sct1rdq_unmapped_error),
    .ue_err        (sct1rdq_ue_err),
    .jid           (sct1rdq_jid),
    .data          (sct1rdq_data),
    .adtype        (sct_adtype[1]),
    .ad            (sct_ad[1])
  );

  sct_rdq_format sct2_fmt_i (
    .clk, .arst_n, .sel_j_adbus,
    .install_state (sct2rdq_install_state),
    .unmapped_error(sct2rdq_unmapped_error),
    .ue_err        (sct2rdq_ue_err),
    .jid           (sct2rdq_jid),
    .data          (sct2rdq_data),
    .adtype        (sct_adtype[2]),
    .ad            (sct_ad[2])
  );

  sct_rdq_format sct3_fmt_i (
    .clk, .arst_n, .sel_j_adbus,
    .install_state (sct3rdq_install_state),
    .unmapped_error(sct3rdq_unmapped_error),
    .ue_err        (sct3rdq_ue_err),
    .jid           (sct3rdq_jid),
    .data          (sct3rdq_data),
    .adtype        (sct_adtype[3]),
    .ad            (sct_ad[3])
  );

  ncio_format ncio_fmt_i (
    .sel_j_adbus,
    .pio_ue       (ncio_pio_ue),
    .pio_be       (ncio_pio_be),
    .pio_ad       (ncio_pio_ad),
    .mondo_agnt_id(ncio_mondo_agnt_id),
    .mondo_cpu_id (ncio_mondo_cpu_id),
    .unused_jid,
    .adtype       (ncio_adtype),
    .ad           (ncio_ad)
  );

  pktout_select select_i (
    .sel_queue, .sel_j_adbus,
    .sct_adtype, .sct_ad,
    .ncio_adtype, .ncio_ad,
    .dbg_data,
    .j_adtype(jbi_io_j_adtype),
    .j_ad
  );

  // Injection and parity on the pin side
  jad_protect protect_i (
    .j_adtype(jbi_io_j_adtype),
    .j_ad,
    .inj_err_j_ad,
    .jbi_io_j_ad,
    .jbi_io_j_adp
  );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);
  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Release on a falling edge, away from the capture edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== jbi_pktout_checker.sv ====
// JBus output checker
`timescale 1ns/10ps
`default_nettype none

module jbi_pktout_checker (
  input  logic                               clk,
  input  logic                               arst_n,
  input  logic                               row_valid,
  input  int                                 row_idx,
  input  logic [pktout_sel_pkg::QSEL_W-1:0]  sel_queue,
  input  logic [pktout_sel_pkg::CSEL_W-1:0]  sel_j_adbus,
  input  logic [pktout_sel_pkg::NUM_SCT-1:0] sct_install_state,
  input  logic [pktout_sel_pkg::NUM_SCT-1:0] sct_unmapped_error,
  input  logic [pktout_sel_pkg::NUM_SCT-1:0] sct_ue_err,
  input  logic [jbus_pkg::JID_W-1:0]         sct_jid [pktout_sel_pkg::NUM_SCT],
  input  logic [jbus_pkg::AD_W-1:0]          sct_data [pktout_sel_pkg::NUM_SCT],
  input  logic                               pio_ue,
  input  logic [jbus_pkg::BE_W-1:0]          pio_be,
  input  logic [jbus_pkg::AD_W/2-1:0]        pio_ad,
  input  logic [jbus_pkg::AID_W-1:0]         mondo_agnt_id,
  input  logic [jbus_pkg::AID_W-1:0]         mondo_cpu_id,
  input  logic [jbus_pkg::JID_W-1:0]         unused_jid,
  input  logic [jbus_pkg::AD_W-1:0]          dbg_data,
  input  logic [jbus_pkg::ADP_W-1:0]         inj_err_j_ad,
  input  logic [jbus_pkg::ADTYPE_W-1:0]      j_adtype,
  input  logic [jbus_pkg::AD_W-1:0]          j_ad,
  input  logic [jbus_pkg::ADP_W-1:0]         j_adp,
  output int                                 rows_checked,
  output int                                 rows_failed,
  output int                                 mismatches
);
  import jbus_pkg::*;
  import pktout_sel_pkg::*;

  // Sample 1 ns before the next rising edge
  localparam int SAMPLE_DELAY = 19;

  logic [NUM_SCT-1:0]  prev_ue;
  logic [ADTYPE_W-1:0] exp_adtype;
  logic [AD_W-1:0]     exp_ad;
  logic [AD_W-1:0]     exp_pin_ad;
  logic [ADP_W-1:0]    exp_adp;

  // Enables in [63:48], code in [47:43], address in [42:0]
  function automatic logic [AD_W/2-1:0] addr_half(input logic [BE_W-1:0] be,
                                                  input logic [TRANS_W-1:0] code,
                                                  input logic [PIO_ADDR_W-1:0] addr);
    logic [AD_W/2-1:0] h;
    h        = '0;
    h[63:48] = be;
    h[47:43] = code;
    h[42:0]  = addr;
    return h;
  endfunction

  task automatic compute_expected();
    int                k;
    logic              lane_xor;
    logic [AD_W/2-1:0] half;
    exp_adtype = '0;
    exp_ad     = '0;
    if (sel_j_adbus == SEL_IDLE) begin
      exp_adtype = IDLE_ADTYPE;
      exp_ad     = '1;
    end else if (sel_queue < NUM_SCT) begin
      k = sel_queue;
      case (sel_j_adbus)
        SEL_RD16: begin
          exp_adtype = {ADTYPE_RD16, sct_jid[k]};
          exp_ad     = sct_data[k];
        end
        SEL_RD64_0: begin
          exp_adtype = {ADTYPE_RD64, sct_jid[k]};
          exp_ad     = sct_data[k];
        end
        SEL_RD64_1: begin
          exp_adtype[6]   = prev_ue[k];
          exp_adtype[4]   = sct_ue_err[k];
          exp_adtype[2:0] = sct_install_state[k] ? INSTALL_SHARED : INSTALL_INVALID;
          exp_ad          = sct_data[k];
        end
        SEL_RD64_2, SEL_RD64_3: begin
          exp_adtype[4] = sct_ue_err[k];
          exp_ad        = sct_data[k];
        end
        SEL_RDER: begin
          exp_adtype  = {ADTYPE_RDER, sct_jid[k]};
          exp_ad      = sct_data[k];
          exp_ad[2:0] = sct_unmapped_error[k] ? RDER_UNMAPPED : RDER_BUS_ERROR;
        end
        default: ;
      endcase
    end else if (sel_queue == LRQ_PIORQQ) begin
      case (sel_j_adbus)
        SEL_NCRD: begin
          exp_adtype = {ADTYPE_NC, unused_jid};
          half       = addr_half(pio_be, TRANS_NCRD, pio_ad[PIO_ADDR_W-1:0]);
          exp_ad     = {half, half};
        end
        SEL_NCWR_0: begin
          exp_adtype = {ADTYPE_NC, {JID_W{1'b0}}};
          half       = addr_half(pio_be, TRANS_NCWR, pio_ad[PIO_ADDR_W-1:0]);
          exp_ad     = {half, half};
        end
        SEL_NCWR_1: begin
          exp_adtype[4] = pio_ue;
          exp_ad        = {pio_ad, pio_ad};
        end
        default: ;
      endcase
    end else if (sel_queue == LRQ_PIOACKQ) begin
      if (sel_j_adbus == SEL_INTACK || sel_j_adbus == SEL_INTNACK) begin
        exp_adtype = {ADTYPE_NC, {JID_W{1'b0}}};
        half = addr_half('0, (sel_j_adbus == SEL_INTACK) ? TRANS_INTACK : TRANS_INTNACK,
                         {2'b00, mondo_agnt_id, mondo_cpu_id, 31'd0});
        exp_ad = {half, half};
      end
    end else if (sel_queue == LRQ_DBGQ && sel_j_adbus == SEL_RD16) begin
      exp_adtype = {ADTYPE_RD16, DBG_TARGET_AID, 2'b00};
      exp_ad     = dbg_data;
    end

    // Injection flips lane bit 0, parity sees the clean data
    exp_pin_ad = exp_ad;
    for (int lane = 0; lane < ADP_W; lane++) begin
      if (inj_err_j_ad[lane])
        exp_pin_ad[lane*LANE_W] = ~exp_pin_ad[lane*LANE_W];
      lane_xor = ^exp_ad[lane*LANE_W +: LANE_W];
      if (lane == ADP_W-1)
        lane_xor = lane_xor ^ (^exp_adtype);
      exp_adp[lane] = ~lane_xor;
    end
  endtask

  task automatic compare_value(input string name, input logic [AD_W-1:0] got,
                               input logic [AD_W-1:0] exp, inout int bad);
    if (got !== exp) begin
      $display("ERROR %0t %s got %0h exp %0h", $time, name, got, exp);
      bad++;
    end
  endtask

  task automatic check_row();
    int bad;
    bad = 0;
    compute_expected();
    compare_value("jbi_io_j_adtype", j_adtype, exp_adtype, bad);
    compare_value("jbi_io_j_ad", j_ad, exp_pin_ad, bad);
    compare_value("jbi_io_j_adp", j_adp, exp_adp, bad);
    rows_checked++;
    mismatches += bad;
    if (bad != 0)
      rows_failed++;
    $display("row %0d queue %0d cycle %0d: %s", row_idx, sel_queue, sel_j_adbus,
             (bad == 0) ? "ok" : "mismatch");
  endtask

  // Previous UE tracks the value seen at the last rising edge
  initial begin
    rows_checked = 0;
    rows_failed  = 0;
    mismatches   = 0;
    prev_ue      = '0;
    forever begin
      @(posedge clk);
      #(SAMPLE_DELAY);
      if (!arst_n) begin
        prev_ue = '0;
      end else begin
        if (row_valid)
          check_row();
        prev_ue = sct_ue_err;
      end
    end
  end

endmodule

`default_nettype wire

// ==== jbi_pktout_mux_props.sv ====
// Select and address-half assertions
`timescale 1ns/10ps
`default_nettype none

module jbi_pktout_mux_props (
  input logic                              clk,
  input logic                              arst_n,
  input logic [pktout_sel_pkg::QSEL_W-1:0] sel_queue,
  input logic [pktout_sel_pkg::CSEL_W-1:0] sel_j_adbus,
  input logic [jbus_pkg::AD_W-1:0]         j_ad
);
  import jbus_pkg::*;
  import pktout_sel_pkg::*;

  int   assert_fails = 0;
  logic pair_legal;
  logic addr_cycle;

  // Each queue owns its own cycle types, idle goes with any queue
  always_comb begin
    case (sel_queue)
      LRQ_SCT0RDQ, LRQ_SCT1RDQ, LRQ_SCT2RDQ, LRQ_SCT3RDQ:
        pair_legal = sel_j_adbus inside {[SEL_IDLE:SEL_RDER]};
      LRQ_PIORQQ:
        pair_legal = sel_j_adbus inside {SEL_IDLE, SEL_NCRD, SEL_NCWR_0, SEL_NCWR_1};
      LRQ_PIOACKQ:
        pair_legal = sel_j_adbus inside {SEL_IDLE, SEL_INTACK, SEL_INTNACK};
      LRQ_DBGQ:
        pair_legal = sel_j_adbus inside {SEL_IDLE, SEL_RD16};
      default:
        pair_legal = (sel_j_adbus == SEL_IDLE);
    endcase
  end

  assign addr_cycle = sel_j_adbus inside {SEL_IDLE, SEL_NCRD, SEL_NCWR_0,
                                          SEL_INTACK, SEL_INTNACK};

  legal_select: assert property (@(posedge clk) disable iff (!arst_n) pair_legal)
    else begin
      $error("Illegal select pair, queue %0d cycle %0d", sel_queue, sel_j_adbus);
      assert_fails++;
    end

  equal_halves: assert property (@(posedge clk) disable iff (!arst_n)
    addr_cycle |-> (j_ad[AD_W-1:AD_W/2] == j_ad[AD_W/2-1:0]))
    else begin
      $error("J_AD halves differ on an address cycle %0d", sel_j_adbus);
      assert_fails++;
    end

endmodule

bind jbi_pktout_mux jbi_pktout_mux_props props_i (
  .clk,
  .arst_n,
  .sel_queue,
  .sel_j_adbus,
  .j_ad
);

`default_nettype wire

// ==== jbi_pktout_mux_tb.sv ====
// JBus output formatter testbench
`timescale 1ns/10ps
`default_nettype none

module jbi_pktout_mux_tb;
  import jbus_pkg::*;
  import pktout_sel_pkg::*;

  localparam int DRIVE_DELAY   = 1;
  localparam int RESET_TIMEOUT = 20;
  localparam int NUM_RANDOM    = 16;

  typedef struct packed {
    logic [QSEL_W-1:0]             sel_queue;
    logic [CSEL_W-1:0]             sel_j_adbus;
    logic [NUM_SCT-1:0]            install_state;
    logic [NUM_SCT-1:0]            unmapped_error;
    logic [NUM_SCT-1:0]            ue_err;
    logic [NUM_SCT-1:0][JID_W-1:0] jid;
    logic [NUM_SCT-1:0][AD_W-1:0]  data;
    logic                          pio_ue;
    logic [BE_W-1:0]               pio_be;
    logic [AD_W/2-1:0]             pio_ad;
    logic [AID_W-1:0]              agnt_id;
    logic [AID_W-1:0]              cpu_id;
    logic [JID_W-1:0]              unused_jid;
    logic [AD_W-1:0]               dbg_data;
    logic [ADP_W-1:0]              inj;
  } row_t;

  row_t        rows [$];
  logic [31:0] lcg_state;

  logic                clk;
  logic                arst_n;
  logic                row_valid;
  int                  row_idx;
  logic [QSEL_W-1:0]   sel_queue;
  logic [CSEL_W-1:0]   sel_j_adbus;
  logic [NUM_SCT-1:0]  sct_install_state;
  logic [NUM_SCT-1:0]  sct_unmapped_error;
  logic [NUM_SCT-1:0]  sct_ue_err;
  logic [JID_W-1:0]    sct_jid [NUM_SCT];
  logic [AD_W-1:0]     sct_data [NUM_SCT];
  logic                pio_ue;
  logic [BE_W-1:0]     pio_be;
  logic [AD_W/2-1:0]   pio_ad;
  logic [AID_W-1:0]    mondo_agnt_id;
  logic [AID_W-1:0]    mondo_cpu_id;
  logic [JID_W-1:0]    unused_jid;
  logic [AD_W-1:0]     dbg_data;
  logic [ADP_W-1:0]    inj_err_j_ad;
  logic [ADTYPE_W-1:0] j_adtype;
  logic [AD_W-1:0]     j_ad;
  logic [ADP_W-1:0]    j_adp;
  int                  rows_checked;
  int                  rows_failed;
  int                  mismatches;
  int                  assert_fails;
  logic                reset_ok;

  tb_clk_gen clk_gen_i (.clk, .arst_n);

  jbi_pktout_mux jbi_pktout_mux_i (
    .clk, .arst_n, .sel_queue, .sel_j_adbus,
    .sct0rdq_install_state (sct_install_state[0]),
    .sct0rdq_unmapped_error(sct_unmapped_error[0]),
    .sct0rdq_jid           (sct_jid[0]),
    .sct0rdq_data          (sct_data[0]),
    .sct0rdq_ue_err        (sct_ue_err[0]),
    .sct1rdq_install_state (sct_install_state[1]),
    .sct1rdq_unmapped_error(sct_unmapped_error[1]),
    .sct1rdq_jid           (sct_jid[1]),
    .sct1rdq_data          (sct_data[1]),
    .sct1rdq_ue_err        (sct_ue_err[1]),
    .sct2rdq_install_state (sct_install_state[2]),
    .sct2rdq_unmapped_error(sct_unmapped_error[2]),
    .sct2rdq_jid           (sct_jid[2]),
    .sct2rdq_data          (sct_data[2]),
    .sct2rdq_ue_err        (sct_ue_err[2]),
    .sct3rdq_install_state (sct_install_state[3]),
    .sct3rdq_unmapped_error(sct_unmapped_error[3]),
    .sct3rdq_jid           (sct_jid[3]),
    .sct3rdq_data          (sct_data[3]),
    .sct3rdq_ue_err        (sct_ue_err[3]),
    .ncio_pio_ue           (pio_ue),
    .ncio_pio_be           (pio_be),
    .ncio_pio_ad           (pio_ad),
    .ncio_mondo_agnt_id    (mondo_agnt_id),
    .ncio_mondo_cpu_id     (mondo_cpu_id),
    .unused_jid, .dbg_data, .inj_err_j_ad,
    .jbi_io_j_adtype       (j_adtype),
    .jbi_io_j_ad           (j_ad),
    .jbi_io_j_adp          (j_adp)
  );

  jbi_pktout_checker checker_i (
    .clk, .arst_n, .row_valid, .row_idx, .sel_queue, .sel_j_adbus,
    .sct_install_state, .sct_unmapped_error, .sct_ue_err, .sct_jid, .sct_data,
    .pio_ue, .pio_be, .pio_ad, .mondo_agnt_id, .mondo_cpu_id, .unused_jid,
    .dbg_data, .inj_err_j_ad, .j_adtype, .j_ad, .j_adp,
    .rows_checked, .rows_failed, .mismatches
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [AD_W-1:0] rand_wide();
    logic [AD_W-1:0] w;
    for (int i = 0; i < AD_W / 32; i++)
      w[i*32 +: 32] = next_rand();
    return w;
  endfunction

  function automatic row_t random_row(input logic [QSEL_W-1:0] q,
                                      input logic [CSEL_W-1:0] c,
                                      input logic [ADP_W-1:0] inj);
    row_t            r;
    logic [31:0]     bits;
    logic [AD_W-1:0] wide;
    bits             = next_rand();
    r.sel_queue      = q;
    r.sel_j_adbus    = c;
    r.inj            = inj;
    r.install_state  = bits[3:0];
    r.unmapped_error = bits[7:4];
    r.ue_err         = bits[11:8];
    r.pio_ue         = bits[12];
    r.pio_be         = bits[31:16];
    for (int k = 0; k < NUM_SCT; k++) begin
      bits      = next_rand();
      r.jid[k]  = bits[JID_W-1:0];
      r.data[k] = rand_wide();
    end
    wide         = rand_wide();
    r.pio_ad     = wide[AD_W/2-1:0];
    r.dbg_data   = rand_wide();
    bits         = next_rand();
    r.agnt_id    = bits[4:0];
    r.cpu_id     = bits[9:5];
    r.unused_jid = bits[15:10];
    return r;
  endfunction

  task automatic build_table();
    row_t              r;
    logic [31:0]       bits;
    logic [QSEL_W-1:0] q;
    logic [CSEL_W-1:0] c;
    // First row after reset sees a clear delayed UE
    r        = random_row(LRQ_SCT0RDQ, SEL_RD64_1, '0);
    r.ue_err = '1;
    rows.push_back(r);
    rows.push_back(random_row(LRQ_SCT2RDQ, SEL_IDLE, '0));
    // Both install states and both RDER codes on every SCT queue
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < NUM_SCT; k++) begin
        for (int s = SEL_RD16; s <= SEL_RDER; s++) begin
          r = random_row(QSEL_W'(k), CSEL_W'(s), '0);
          r.install_state  = {NUM_SCT{p[0]}};
          r.unmapped_error = {NUM_SCT{~p[0]}};
          // Delayed and current UE differ on every RD64_1 row here
          if (s == SEL_RD64_0)
            r.ue_err = {NUM_SCT{p[0]}};
          else if (s == SEL_RD64_1)
            r.ue_err = {NUM_SCT{~p[0]}};
          rows.push_back(r);
        end
      end
    end
    rows.push_back(random_row(LRQ_PIORQQ, SEL_NCRD, '0));
    rows.push_back(random_row(LRQ_PIORQQ, SEL_NCWR_0, '0));
    r        = random_row(LRQ_PIORQQ, SEL_NCWR_1, '0);
    r.pio_ue = 1'b1;
    rows.push_back(r);
    rows.push_back(random_row(LRQ_PIOACKQ, SEL_INTACK, '0));
    rows.push_back(random_row(LRQ_PIOACKQ, SEL_INTNACK, '0));
    rows.push_back(random_row(LRQ_DBGQ, SEL_RD16, '0));
    rows.push_back(random_row(LRQ_PIOACKQ, SEL_IDLE, '0));
    // Random legal pairs with random injection masks
    for (int i = 0; i < NUM_RANDOM; i++) begin
      bits = next_rand();
      q    = QSEL_W'(bits[7:0] % 7);
      case (q)
        LRQ_PIORQQ:  c = SEL_NCRD + CSEL_W'(bits[15:8] % 3);
        LRQ_PIOACKQ: c = SEL_INTACK + CSEL_W'(bits[15:8] % 2);
        LRQ_DBGQ:    c = SEL_RD16;
        default:     c = SEL_RD16 + CSEL_W'(bits[15:8] % 6);
      endcase
      rows.push_back(random_row(q, c, bits[19:16]));
    end
  endtask

  task automatic apply_row(input row_t r);
    sel_queue          = r.sel_queue;
    sel_j_adbus        = r.sel_j_adbus;
    sct_install_state  = r.install_state;
    sct_unmapped_error = r.unmapped_error;
    sct_ue_err         = r.ue_err;
    for (int k = 0; k < NUM_SCT; k++) begin
      sct_jid[k]  = r.jid[k];
      sct_data[k] = r.data[k];
    end
    pio_ue        = r.pio_ue;
    pio_be        = r.pio_be;
    pio_ad        = r.pio_ad;
    mondo_agnt_id = r.agnt_id;
    mondo_cpu_id  = r.cpu_id;
    unused_jid    = r.unused_jid;
    dbg_data      = r.dbg_data;
    inj_err_j_ad  = r.inj;
  endtask

  task automatic init_inputs();
    row_t r;
    r             = '0;
    r.sel_j_adbus = SEL_IDLE;
    apply_row(r);
    row_valid = 1'b0;
    row_idx   = 0;
  endtask

  initial begin
    int cycles;
    lcg_state = 32'h6049;
    init_inputs();
    build_table();
    cycles = 0;
    while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    reset_ok = (arst_n === 1'b1);
    if (reset_ok) begin
      for (int i = 0; i < rows.size(); i++) begin
        @(posedge clk);
        #(DRIVE_DELAY);
        apply_row(rows[i]);
        row_idx   = i;
        row_valid = 1'b1;
      end
      @(posedge clk);
      #(DRIVE_DELAY);
      row_valid = 1'b0;
    end else begin
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
    end
    assert_fails = jbi_pktout_mux_i.props_i.assert_fails;
    if (reset_ok && rows_checked != rows.size())
      $display("Checker saw %0d rows but %0d were driven", rows_checked, rows.size());
    $display("Rows %0d, failed rows %0d, mismatches %0d, assertion failures %0d",
             rows_checked, rows_failed, mismatches, assert_fails);
    if (reset_ok && rows_checked == rows.size() && mismatches == 0 && assert_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
jbus_pkg.sv
pktout_sel_pkg.sv
sct_rdq_format.sv
ncio_format.sv
pktout_select.sv
jad_protect.sv
jbi_pktout_mux.sv
tb_clk_gen.sv
jbi_pktout_checker.sv
jbi_pktout_mux_props.sv
jbi_pktout_mux_tb.sv

// ==== Bender.yml ====
package:
  name: jbi_pktout_mux

sources:
  - jbus_pkg.sv
  - pktout_sel_pkg.sv
  - sct_rdq_format.sv
  - ncio_format.sv
  - pktout_select.sv
  - jad_protect.sv
  - jbi_pktout_mux.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - jbi_pktout_checker.sv
      - jbi_pktout_mux_props.sv
      - jbi_pktout_mux_tb.sv
